/* verilog.f */
mdll_pkg.sv
mdll_filter_regs.sv
mdll_bw_decode.sv
mdll_iir_core.sv
mdll_dac_output.sv
mdll_supply_dac_filter.sv
tb_mdll_supply_dac_filter.sv

/* Bender.yml */
package:
  name: mdll_supply_dac_filter

sources:
  - mdll_pkg.sv
  - mdll_filter_regs.sv
  - mdll_bw_decode.sv
  - mdll_iir_core.sv
  - mdll_dac_output.sv
  - mdll_supply_dac_filter.sv
  - target: test
    files:
      - tb_mdll_supply_dac_filter.sv

/* tb_mdll_supply_dac_filter.sv */
`default_nettype none

module tb_mdll_supply_dac_filter;

  timeunit 1ns;
  timeprecision 1ps;

  import mdll_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_STEP     = 40;
  localparam int N_RAND     = 200;
  // reset, step phases, random phases with gaps, about 20 bus accesses
  localparam int STIM_CYCLES = 200 + 4 * (N_STEP + 20) + 5 * N_RAND + 20 * 12;
  localparam int MARGIN_NS   = 2000;
  // smoothing coefficient per ones count of the bandwidth code
  localparam int ALPHA_REF [8] = '{128, 96, 72, 54, 40, 30, 22, 16};

  logic                  iir_clk;
  logic                  rst_n;
  axi_addr_t             awaddr;
  logic                  awvalid;
  logic                  awready;
  axi_data_t             wdata;
  logic [AXI_STRB_W-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  axi_resp_t             bresp;
  logic                  bvalid;
  logic                  bready;
  axi_addr_t             araddr;
  logic                  arvalid;
  logic                  arready;
  axi_data_t             rdata;
  axi_resp_t             rresp;
  logic                  rvalid;
  logic                  rready;
  dac_code_t             vin_code;
  logic                  vin_valid;
  dac_code_t             vout_code;
  logic                  vout_valid;

  // reference model state in 10.8 fixed point
  int        st_m;
  bit        primed_m;
  bit        en_m;
  int        alpha_m;
  bw_thm_t   bw_m;
  bit        bad_m;
  int        last_vout;
  int        exp_q [$];
  // queue head as seen on the falling edge
  dac_code_t exp_code;
  bit        exp_pending;
  axi_resp_t exp_bresp;
  axi_data_t exp_rdata;
  axi_resp_t exp_rresp;
  int        mismatch_errs;
  int        other_errs;

  mdll_supply_dac_filter mdll_supply_dac_filter_i (.*);

  initial begin
    iir_clk = 1'b0;
    forever #(CLK_PERIOD / 2) iir_clk = ~iir_clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------

  task automatic predict_output(input int code);
    int err;
    int out;
    if (en_m) begin
      if (!primed_m) begin
        // preload sets the DC point
        st_m     = code * 256;
        primed_m = 1'b1;
      end else begin
        err  = code * 256 - st_m;
        // floor division by 256
        st_m = st_m + ((alpha_m * err) >>> 8);
      end
      out = (st_m + 128) / 256;
      if (out > 1023) begin
        out = 1023;
      end
      exp_q.push_back(out);
      last_vout = out;
    end
  endtask

  always @(posedge iir_clk) begin
    if (vout_valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
  end

  always @(negedge iir_clk) begin
    exp_pending = (exp_q.size() > 0);
    if (exp_pending) begin
      exp_code = dac_code_t'(exp_q[0]);
    end
  end

  // ------------------------------
  // stimulus tasks
  // ------------------------------

  task automatic send_sample(input int code);
    vin_code  <= dac_code_t'(code);
    vin_valid <= 1'b1;
    predict_output(code);
    @(posedge iir_clk);
  endtask

  task automatic idle_stream(input int n);
    vin_valid <= 1'b0;
    repeat (n) @(posedge iir_clk);
  endtask

  task automatic write_reg(input axi_addr_t addr, input axi_data_t data,
                           input axi_resp_t resp, input int hold);
    int ones;
    awaddr    <= addr;
    wdata     <= data;
    wstrb     <= '1;
    awvalid   <= 1'b1;
    wvalid    <= 1'b1;
    bready    <= 1'b0;
    exp_bresp = resp;
    do @(posedge iir_clk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge iir_clk); while (!bvalid);
    // response stalled for a few cycles
    repeat (hold) @(posedge iir_clk);
    bready <= 1'b1;
    @(posedge iir_clk);
    bready <= 1'b0;
    if (resp == RESP_OKAY) begin
      case (addr)
        REG_CTRL: begin
          en_m = data[0];
          if (!en_m) begin
            primed_m = 1'b0;
          end
        end
        REG_BW: begin
          bw_m    = data[N_DAC_BW-1:0];
          ones    = $countones(bw_m);
          alpha_m = ALPHA_REF[ones];
          // legal only as a run of ones from bit 0
          if (bw_m != bw_thm_t'((1 << ones) - 1)) begin
            bad_m = 1'b1;
          end
        end
        REG_STATUS: begin
          if (data[0]) begin
            bad_m = 1'b0;
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic read_reg(input axi_addr_t addr, input axi_data_t data,
                          input axi_resp_t resp, input int hold);
    araddr    <= addr;
    arvalid   <= 1'b1;
    rready    <= 1'b0;
    exp_rdata = data;
    exp_rresp = resp;
    do @(posedge iir_clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge iir_clk); while (!rvalid);
    repeat (hold) @(posedge iir_clk);
    rready <= 1'b1;
    @(posedge iir_clk);
    rready <= 1'b0;
  endtask

  // ------------------------------
  // checks
  // ------------------------------

  // handshake outputs come out of reset low
  a_reset_idle: assert property (@(posedge iir_clk)
    $rose(rst_n) |-> !(vout_valid || awready || wready || bvalid || arready || rvalid))
    else begin
      other_errs++;
      $display("a valid or ready output is high after reset");
    end

  a_vout_expected: assert property (@(posedge iir_clk) disable iff (!rst_n)
    vout_valid |-> exp_pending)
    else begin
      other_errs++;
      $display("vout_valid strobe at %0t with no sample expected", $time);
    end

  // strobe lands one edge after the sampling edge
  a_vout_valid: assert property (@(posedge iir_clk) disable iff (!rst_n)
    vout_valid == $past(vin_valid && en_m, 2))
    else begin
      mismatch_errs++;
      $display("MISMATCH vout_valid exp %h got %h", !$sampled(vout_valid),
               $sampled(vout_valid));
    end

  a_vout_code: assert property (@(posedge iir_clk) disable iff (!rst_n)
    (vout_valid && exp_pending) |-> (vout_code == exp_code))
    else begin
      mismatch_errs++;
      $display("MISMATCH vout_code exp %h got %h", exp_code, $sampled(vout_code));
    end

  a_bresp: assert property (@(posedge iir_clk) disable iff (!rst_n)
    bvalid |-> (bresp == exp_bresp))
    else begin
      mismatch_errs++;
      $display("MISMATCH bresp exp %h got %h", exp_bresp, $sampled(bresp));
    end

  a_rdata: assert property (@(posedge iir_clk) disable iff (!rst_n)
    rvalid |-> (rdata == exp_rdata))
    else begin
      mismatch_errs++;
      $display("MISMATCH rdata exp %h got %h", exp_rdata, $sampled(rdata));
    end

  a_rresp: assert property (@(posedge iir_clk) disable iff (!rst_n)
    rvalid |-> (rresp == exp_rresp))
    else begin
      mismatch_errs++;
      $display("MISMATCH rresp exp %h got %h", exp_rresp, $sampled(rresp));
    end

  // stalled responses hold their valid and payload
  a_b_hold: assert property (@(posedge iir_clk) disable iff (!rst_n)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
      other_errs++;
      $display("write response changed while bready was low");
    end

  a_r_hold: assert property (@(posedge iir_clk) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
      other_errs++;
      $display("read data changed while rready was low");
    end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h89d));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    vin_code  = '0;
    vin_valid = 1'b0;
    alpha_m   = ALPHA_REF[0];
    repeat (8) @(posedge iir_clk);
    rst_n <= 1'b1;
    @(posedge iir_clk);
    // reset values
    read_reg(REG_BW, '0, RESP_OKAY, 0);
    read_reg(REG_CTRL, '0, RESP_OKAY, 0);
    read_reg(REG_STATUS, '0, RESP_OKAY, 0);
    // first sample after enable preloads
    write_reg(REG_CTRL, 32'h1, RESP_OKAY, 0);
    send_sample(512);
    idle_stream(2);
    // step response per bandwidth code
    foreach (ALPHA_REF[i]) begin
      if (i == 0 || i == 1 || i == 3 || i == 7) begin
        write_reg(REG_BW, axi_data_t'((1 << i) - 1), RESP_OKAY, 0);
        repeat (4) send_sample(100);
        repeat (N_STEP) send_sample(900);
        idle_stream(2);
      end
    end
    // random codes back to back then with gaps
    repeat (N_RAND) send_sample(int'($urandom_range(0, 1023)));
    idle_stream(1);
    repeat (N_RAND) begin
      send_sample(int'($urandom_range(0, 1023)));
      if ($urandom_range(0, 1) == 1) begin
        idle_stream(int'($urandom_range(1, 3)));
      end
    end
    idle_stream(2);
    // gapped code sets the sticky flag until cleared
    write_reg(REG_BW, 32'h05, RESP_OKAY, 2);
    read_reg(REG_STATUS, axi_data_t'(bad_m), RESP_OKAY, 0);
    repeat (20) send_sample(int'($urandom_range(0, 1023)));
    idle_stream(2);
    write_reg(REG_STATUS, 32'h1, RESP_OKAY, 0);
    read_reg(REG_STATUS, axi_data_t'(bad_m), RESP_OKAY, 0);
    // disabled filter drops samples
    write_reg(REG_CTRL, 32'h0, RESP_OKAY, 0);
    repeat (10) send_sample(int'($urandom_range(0, 1023)));
    idle_stream(4);
    read_reg(REG_CTRL, '0, RESP_OKAY, 1);
    write_reg(REG_CTRL, 32'h1, RESP_OKAY, 0);
    send_sample(300);
    repeat (10) send_sample(700);
    idle_stream(3);
    // readback and unmapped addresses
    read_reg(REG_VOUT, axi_data_t'(last_vout), RESP_OKAY, 3);
    write_reg(4'h2, 32'h7f, RESP_SLVERR, 2);
    read_reg(4'h6, '0, RESP_SLVERR, 1);
    read_reg(REG_BW, axi_data_t'(bw_m), RESP_OKAY, 0);
    idle_stream(4);
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d expected output codes never appeared on vout", exp_q.size());
    end
    $display("checks done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(STIM_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("timeout: run did not finish within %0d ns", STIM_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* mdll_supply_dac_filter.sv */
`default_nettype none

module mdll_supply_dac_filter (
  input  wire                            iir_clk,
  input  wire                            rst_n,
  // config bus
  input  mdll_pkg::axi_addr_t            awaddr,
  input  wire                            awvalid,
  output logic                           awready,
  input  mdll_pkg::axi_data_t            wdata,
  input  wire [mdll_pkg::AXI_STRB_W-1:0] wstrb,
  input  wire                            wvalid,
  output logic                           wready,
  output mdll_pkg::axi_resp_t            bresp,
  output logic                           bvalid,
  input  wire                            bready,
  input  mdll_pkg::axi_addr_t            araddr,
  input  wire                            arvalid,
  output logic                           arready,
  output mdll_pkg::axi_data_t            rdata,
  output mdll_pkg::axi_resp_t            rresp,
  output logic                           rvalid,
  input  wire                            rready,
  // supply code stream
  input  mdll_pkg::dac_code_t            vin_code,
  input  wire                            vin_valid,
  output mdll_pkg::dac_code_t            vout_code,
  output logic                           vout_valid
);

  import mdll_pkg::*;

  logic        enable;
  bw_thm_t     bw_thm;
  alpha_t      alpha;
  logic        bad_thm;
  filt_state_t state;
  logic        state_valid;

  // ------------------------------
  // input side
  // ------------------------------

  mdll_filter_regs mdll_filter_regs_i (
    .iir_clk   (iir_clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .enable    (enable),
    .bw_thm    (bw_thm),
    .bad_thm   (bad_thm),
    .vout_code (vout_code)
  );

  // ------------------------------
  // processing
  // ------------------------------

  mdll_bw_decode mdll_bw_decode_i (
    .bw_thm  (bw_thm),
    .alpha   (alpha),
    .bad_thm (bad_thm)
  );

  mdll_iir_core mdll_iir_core_i (
    .iir_clk     (iir_clk),
    .rst_n       (rst_n),
    .enable      (enable),
    .alpha       (alpha),
    .vin_code    (vin_code),
    .vin_valid   (vin_valid),
    .state       (state),
    .state_valid (state_valid)
  );

  // ------------------------------
  // output side
  // ------------------------------

  mdll_dac_output mdll_dac_output_i (
    .iir_clk     (iir_clk),
    .rst_n       (rst_n),
    .state       (state),
    .state_valid (state_valid),
    .vout_code   (vout_code),
    .vout_valid  (vout_valid)
  );

endmodule

`default_nettype wire

/* mdll_dac_output.sv */
`default_nettype none

module mdll_dac_output (
  input  wire                   iir_clk,
  input  wire                   rst_n,
  input  mdll_pkg::filt_state_t state,
  input  wire                   state_valid,
  output mdll_pkg::dac_code_t   vout_code,
  output logic                  vout_valid
);

  import mdll_pkg::*;

  // state plus half an LSB, with carry bit
  logic [N_STATE:0] rnd;
  dac_code_t        code_sat;

  // ------------------------------
  // round and clamp
  // ------------------------------

  assign rnd = {1'b0, state} + {1'b0, RND_HALF};

  // carry out means the rounded code passed the top of the DAC
  assign code_sat = rnd[N_STATE] ? DAC_MAX : rnd[N_STATE-1:N_FRAC];

  // ------------------------------
  // output register
  // ------------------------------

  // code is read back over the bus, so it starts from a known value
  always_ff @(posedge iir_clk or negedge rst_n) begin
    if (!rst_n) begin
      vout_code  <= '0;
      vout_valid <= 1'b0;
    end else begin
      vout_valid <= state_valid;
      // hold between strobes
      if (state_valid) begin
        vout_code <= code_sat;
      end
    end
  end

endmodule

`default_nettype wire

/* mdll_iir_core.sv */
`default_nettype none

module mdll_iir_core (
  input  wire                   iir_clk,
  input  wire                   rst_n,
  input  wire                   enable,
  input  mdll_pkg::alpha_t      alpha,
  input  mdll_pkg::dac_code_t   vin_code,
  input  wire                   vin_valid,
  output mdll_pkg::filt_state_t state,
  output logic                  state_valid
);

  import mdll_pkg::*;

  // first sample after enable sets the DC point
  logic                        primed;
  logic                        accept;
  filt_state_t                 target;
  // signed, one bit wider than the state
  logic signed [N_STATE:0]     err;
  logic signed [N_STATE+N_ALPHA+1:0] prod;
  // two spare bits to see any overflow
  logic signed [N_STATE+1:0]   delta;
  logic signed [N_STATE+1:0]   nxt;

  assign accept = enable && vin_valid;

  // ------------------------------
  // update arithmetic
  // ------------------------------

  // input code aligned to the 10.8 state
  assign target = {vin_code, {N_FRAC{1'b0}}};

  assign err  = $signed({1'b0, target}) - $signed({1'b0, state});
  assign prod = err * $signed({1'b0, alpha});

  // divide by 256, slice of a signed value floors toward -inf
  assign delta = prod[N_FRAC +: N_STATE + 2];
  assign nxt   = $signed({2'b00, state}) + delta;

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge iir_clk or negedge rst_n) begin
    if (!rst_n) begin
      primed      <= 1'b0;
      state_valid <= 1'b0;
    end else begin
      // one strobe per accepted sample
      state_valid <= accept;
      if (!enable) begin
        primed <= 1'b0;
      end else if (vin_valid) begin
        primed <= 1'b1;
      end
    end
  end

  // ------------------------------
  // state
  // ------------------------------

  always_ff @(posedge iir_clk) begin
    if (accept) begin
      if (!primed) begin
        // preload
        state <= target;
      end else begin
        state <= nxt[N_STATE-1:0];
      end
    end
    // disabled or no sample: hold
  end

  // with alpha at most one half the state moves toward the input,
  // so the 10 bit integer part never wraps
  a_no_ovf: assert property (@(posedge iir_clk) disable iff (!rst_n)
    (accept && primed) |-> (nxt[N_STATE+1:N_STATE] == 2'b00));

endmodule

`default_nettype wire

/* mdll_bw_decode.sv */
`default_nettype none

module mdll_bw_decode (
  input  mdll_pkg::bw_thm_t bw_thm,
  output mdll_pkg::alpha_t  alpha,
  output logic              bad_thm
);

  import mdll_pkg::*;

  // number of switched-in caps
  bw_cnt_t ones_cnt;
  // clean thermometer code with the same ones count
  bw_thm_t thm_ref;

  // ------------------------------
  // cap count
  // ------------------------------

  always_comb begin
    ones_cnt = '0;
    for (int i = 0; i < N_DAC_BW; i++) begin
      ones_cnt = ones_cnt + bw_cnt_t'(bw_thm[i]);
    end
  end

  // cap count -> coefficient, stands in for R*C vs the update period
  assign alpha = ALPHA_LUT[ones_cnt];

  // ------------------------------
  // code check
  // ------------------------------

  // legal code is a run of ones from bit 0
  assign thm_ref = bw_thm_t'((1 << ones_cnt) - 1);

  // a gapped code still picks alpha by its ones count
  assign bad_thm = (thm_ref != bw_thm);

endmodule

`default_nettype wire

/* mdll_filter_regs.sv */
`default_nettype none

module mdll_filter_regs (
  input  wire                          iir_clk,
  input  wire                          rst_n,
  // write address / data
  input  mdll_pkg::axi_addr_t          awaddr,
  input  wire                          awvalid,
  output logic                         awready,
  input  mdll_pkg::axi_data_t          wdata,
  input  wire [mdll_pkg::AXI_STRB_W-1:0] wstrb,
  input  wire                          wvalid,
  output logic                         wready,
  output mdll_pkg::axi_resp_t          bresp,
  output logic                         bvalid,
  input  wire                          bready,
  // read address / data
  input  mdll_pkg::axi_addr_t          araddr,
  input  wire                          arvalid,
  output logic                         arready,
  output mdll_pkg::axi_data_t          rdata,
  output mdll_pkg::axi_resp_t          rresp,
  output logic                         rvalid,
  input  wire                          rready,
  // filter side
  output logic                         enable,
  output mdll_pkg::bw_thm_t            bw_thm,
  input  wire                          bad_thm,
  input  mdll_pkg::dac_code_t          vout_code
);

  import mdll_pkg::*;

  axi_state_e axi_state;
  axi_resp_t  wr_resp;
  axi_resp_t  rd_resp;
  axi_data_t  rd_data;
  // high for one cycle after a bandwidth write lands
  logic       bw_upd;
  logic       bad_flag;

  // ------------------------------
  // address decode
  // ------------------------------

  // VOUT write is accepted and dropped
  always_comb begin
    case (awaddr)
      REG_CTRL, REG_BW, REG_STATUS, REG_VOUT: wr_resp = RESP_OKAY;
      default:                                wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      REG_CTRL:   rd_data[0]         = enable;
      REG_BW:     rd_data[N_DAC_BW-1:0] = bw_thm;
      REG_STATUS: rd_data[0]         = bad_flag;
      REG_VOUT:   rd_data[N_DAC-1:0] = vout_code;
      default:    rd_resp            = RESP_SLVERR;
    endcase
  end

  // ------------------------------
  // bus FSM and register bank
  // ------------------------------

  always_ff @(posedge iir_clk or negedge rst_n) begin
    if (!rst_n) begin
      axi_state <= AXI_IDLE;
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= RESP_OKAY;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rresp     <= RESP_OKAY;
      rdata     <= '0;
      enable    <= 1'b0;
      bw_thm    <= '0;
      bw_upd    <= 1'b0;
      bad_flag  <= 1'b0;
    end else begin
      bw_upd <= 1'b0;
      // decoder output settles the cycle after the code lands
      if (bw_upd && bad_thm) begin
        bad_flag <= 1'b1;
      end
      case (axi_state)
        AXI_IDLE: begin
          if (awready) begin
            // write handshake edge, registers take the new value here
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b1;
            bresp     <= wr_resp;
            axi_state <= AXI_RESP;
            if (wstrb[0]) begin
              case (awaddr)
                REG_CTRL: enable <= wdata[0];
                REG_BW: begin
                  bw_thm <= wdata[N_DAC_BW-1:0];
                  bw_upd <= 1'b1;
                end
                REG_STATUS: begin
                  // write one to clear
                  if (wdata[0]) begin
                    bad_flag <= 1'b0;
                  end
                end
                default: ;
              endcase
            end
          end else if (arready) begin
            arready   <= 1'b0;
            rvalid    <= 1'b1;
            rdata     <= rd_data;
            rresp     <= rd_resp;
            axi_state <= AXI_RDATA;
          end else if (awvalid && wvalid) begin
            // write wins over a pending read
            awready <= 1'b1;
            wready  <= 1'b1;
          end else if (arvalid) begin
            arready <= 1'b1;
          end
        end
        AXI_RESP: begin
          // hold response until the master takes it
          if (bready) begin
            bvalid    <= 1'b0;
            axi_state <= AXI_IDLE;
          end
        end
        AXI_RDATA: begin
          if (rready) begin
            rvalid    <= 1'b0;
            axi_state <= AXI_IDLE;
          end
        end
        default: axi_state <= AXI_IDLE;
      endcase
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // single outstanding transaction
  a_one_resp: assert property (@(posedge iir_clk) disable iff (!rst_n)
    !(bvalid && rvalid));

  // ready only offered to a master that holds both valids
  a_aw_hs: assert property (@(posedge iir_clk) disable iff (!rst_n)
    awready |-> (awvalid && wvalid));

endmodule

`default_nettype wire

/* mdll_pkg.sv */
`default_nettype none

package mdll_pkg;

  // ------------------------------
  // filter datapath widths
  // ------------------------------

  // thermometer bandwidth code, one bit per switched cap
  localparam int N_DAC_BW = 7;
  localparam int N_DAC    = 10;
  // fraction bits carried in the IIR state
  localparam int N_FRAC   = 8;
  localparam int N_STATE  = N_DAC + N_FRAC;
  localparam int N_ALPHA  = 8;
  // ones count of the bandwidth code, 0..N_DAC_BW
  localparam int N_BW_CNT = $clog2(N_DAC_BW + 1);

  typedef logic [N_DAC-1:0]    dac_code_t;
  typedef logic [N_DAC_BW-1:0] bw_thm_t;
  typedef logic [N_BW_CNT-1:0] bw_cnt_t;
  // coefficient as a fraction of 2**N_ALPHA
  typedef logic [N_ALPHA-1:0]  alpha_t;
  // 10.8 unsigned fixed point
  typedef logic [N_STATE-1:0]  filt_state_t;

  // top code of the DAC
  localparam dac_code_t   DAC_MAX  = '1;
  // half an LSB of the output code, for round to nearest
  localparam filt_state_t RND_HALF = filt_state_t'(1 << (N_FRAC - 1));

  // smoothing coefficient per ones count
  // more caps on the supply node -> slower node -> smaller alpha
  localparam alpha_t ALPHA_LUT [2**N_BW_CNT] = '{
    8'd128, 8'd96, 8'd72, 8'd54, 8'd40, 8'd30, 8'd22, 8'd16
  };

  // ------------------------------
  // AXI4-Lite config bus
  // ------------------------------

  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [1:0]            axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // register map
  localparam axi_addr_t REG_CTRL   = 4'h0;  // bit 0 enable
  localparam axi_addr_t REG_BW     = 4'h4;  // bits 6..0 thermometer code
  localparam axi_addr_t REG_STATUS = 4'h8;  // bit 0 sticky bad code, w1c
  localparam axi_addr_t REG_VOUT   = 4'hc;  // last output code, read only

  // bus FSM, one transaction in flight
  typedef enum logic [1:0] {
    AXI_IDLE,
    AXI_RESP,
    AXI_RDATA
  } axi_state_e;

endpackage

`default_nettype wire
